// ==== design/acc_pkg.sv ====
// widths are fixed at a 64-bit word of two 32-bit lanes; the memory side is little-endian
package acc_pkg;

  // memory byte address
  localparam int addr_w = 64;

  // one bus and stream word
  localparam int data_w = 64;

  // accumulation lane
  localparam int lane_w = 32;

  localparam int n_bytes = data_w / 8;
  localparam int n_lanes = data_w / lane_w;

  typedef logic [addr_w-1:0] addr_t;

  // one data word seen either as bytes or as accumulator lanes
  typedef union packed {
    logic [n_bytes-1:0][7:0]       bytes;
    logic [n_lanes-1:0][lane_w-1:0] lanes;
  } word_u;

endpackage

// ==== design/acc_eng_ctrl.sv ====
// ap_start is ignored while an operation runs; one operation is in flight at a time
`timescale 1ns/1ps

module acc_eng_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic ap_start,
  input  logic end_conv,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready,
  output logic op_start
);

  logic busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      op_start <= 1'b0;
      ap_done  <= 1'b0;
      ap_ready <= 1'b0;
    end else begin
      op_start <= ap_start && !busy;
      ap_done  <= end_conv;
      ap_ready <= end_conv;
      // set on launch, cleared when the engine reports the end
      if (ap_start && !busy) begin
        busy <= 1'b1;
      end else if (end_conv) begin
        busy <= 1'b0;
      end
    end
  end

  // idle again in the same cycle as ap_done
  assign ap_idle = !busy;

endmodule

// ==== design/mem_read_master.sv ====
// one burst of word_num beats (1 to 16) per start; base must be burst aligned and held stable
`timescale 1ns/1ps

module mem_read_master import acc_pkg::*; #(
  parameter int word_num = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  addr_t      addr,
  // AXI read address channel
  output logic       arvalid,
  input  logic       arready,
  output addr_t      araddr,
  output logic [7:0] arlen,
  // AXI read data channel
  input  logic       rvalid,
  output logic       rready,
  input  word_u      rdata,
  input  logic       rlast,
  // stream towards the engine
  output logic       tvalid,
  input  logic       tready,
  output word_u      tdata,
  output logic       tlast
);

  // one outstanding request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arvalid <= 1'b0;
    end else if (start) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      araddr <= addr;
    end
  end

  assign arlen = 8'(word_num - 1);

  // beats pass straight through, so stream back-pressure stalls the bus
  assign tvalid = rvalid;
  assign rready = tready;
  assign tlast  = rlast;

  // memory holds byte 0 at the low end; swap the whole word
  always_comb begin
    for (int i = 0; i < n_bytes; i++) begin
      tdata.bytes[i] = rdata.bytes[n_bytes-1-i];
    end
  end

endmodule

// ==== design/mem_write_master.sv ====
// single-beat write only; start must not arrive before done of the previous write
`timescale 1ns/1ps

module mem_write_master import acc_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  addr_t              addr,
  input  word_u              data,
  // AXI write address channel
  output logic               awvalid,
  input  logic               awready,
  output addr_t              awaddr,
  output logic [7:0]         awlen,
  // AXI write data channel
  output logic               wvalid,
  input  logic               wready,
  output word_u              wdata,
  output logic [n_bytes-1:0] wstrb,
  output logic               wlast,
  // AXI write response channel
  input  logic               bvalid,
  output logic               bready,
  output logic               done
);

  localparam int lane_bytes = lane_w / 8;

  word_u data_q;
  logic  aw_open;
  logic  w_open;

  always_ff @(posedge clk) begin
    if (start) begin
      data_q <= data;
      awaddr <= addr;
    end
  end

  // channels still waiting after this edge
  assign aw_open = awvalid && !awready;
  assign w_open  = wvalid && !wready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= bready && bvalid;
      if (start) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (awready) awvalid <= 1'b0;
        if (wready) wvalid <= 1'b0;
      end
      // response phase opens once both address and data are taken
      if ((awvalid || wvalid) && !aw_open && !w_open) begin
        bready <= 1'b1;
      end else if (bvalid) begin
        bready <= 1'b0;
      end
    end
  end

  // byte swap inside every 32-bit lane
  always_comb begin
    for (int l = 0; l < n_lanes; l++) begin
      for (int b = 0; b < lane_bytes; b++) begin
        wdata.lanes[l][b*8 +: 8] = data_q.lanes[l][(lane_bytes-1-b)*8 +: 8];
      end
    end
  end

  assign awlen = 8'd0;
  assign wlast = 1'b1;
  assign wstrb = '1;

endmodule

// ==== design/conv_engine.sv ====
// both operand blocks must hold word_num words; the accumulator wraps silently at 32 bits
`timescale 1ns/1ps

module conv_engine import acc_pkg::*; #(
  parameter int word_num = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  op_start,
  output logic  ifm_start,
  output logic  wgt_start,
  input  logic  ifm_tvalid,
  output logic  ifm_tready,
  input  word_u ifm_tdata,
  input  logic  ifm_tlast,
  input  logic  wgt_tvalid,
  output logic  wgt_tready,
  input  word_u wgt_tdata,
  output logic  ofm_start,
  output word_u ofm_data,
  input  logic  ofm_done,
  output logic  end_conv
);

  localparam int cnt_w = $clog2(word_num) + 1;

  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_launch = 3'd1;
  localparam logic [2:0] st_run    = 3'd2;
  localparam logic [2:0] st_write  = 3'd3;
  localparam logic [2:0] st_wait   = 3'd4;

  logic [2:0]       state;
  logic [cnt_w-1:0] pair_cnt;
  logic             pair_fire;
  logic             last_pair;
  word_u            acc;
  word_u            acc_next;

  // join: a pair moves only when both streams offer a word
  assign ifm_tready = (state == st_run) && wgt_tvalid;
  assign wgt_tready = (state == st_run) && ifm_tvalid;
  assign pair_fire  = (state == st_run) && ifm_tvalid && wgt_tvalid;
  // also stop after word_num pairs
  assign last_pair  = ifm_tlast || (pair_cnt == cnt_w'(word_num - 1));

  assign ifm_start = (state == st_launch);
  assign wgt_start = (state == st_launch);
  assign ofm_start = (state == st_write);
  assign ofm_data  = acc;

  // four unsigned byte products summed into each lane
  always_comb begin
    acc_next = acc;
    for (int l = 0; l < n_lanes; l++) begin
      for (int b = 0; b < lane_w / 8; b++) begin
        acc_next.lanes[l] = acc_next.lanes[l]
          + lane_w'(ifm_tdata.lanes[l][b*8 +: 8]) * lane_w'(wgt_tdata.lanes[l][b*8 +: 8]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_launch) begin
      acc      <= '0;
      pair_cnt <= '0;
    end else if (pair_fire) begin
      acc      <= acc_next;
      pair_cnt <= pair_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      end_conv <= 1'b0;
    end else begin
      end_conv <= (state == st_wait) && ofm_done;
      case (state)
        st_idle:   if (op_start) state <= st_launch;
        st_launch: state <= st_run;
        st_run:    if (pair_fire && last_pair) state <= st_write;
        st_write:  state <= st_wait;
        st_wait:   if (ofm_done) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

endmodule

// ==== design/krnl_acc.sv ====
// base addresses must stay stable from ap_start until ap_done; word_num ranges 1 to 16
`timescale 1ns/1ps

module krnl_acc import acc_pkg::*; #(
  parameter int word_num = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  // kernel control
  input  logic               ap_start,
  output logic               ap_idle,
  output logic               ap_done,
  output logic               ap_ready,
  input  addr_t              ifm_addr_base,
  input  addr_t              wgt_addr_base,
  input  addr_t              ofm_addr_base,
  // ifm read channel
  output logic               m_ifm_arvalid,
  input  logic               m_ifm_arready,
  output addr_t              m_ifm_araddr,
  output logic [7:0]         m_ifm_arlen,
  input  logic               m_ifm_rvalid,
  output logic               m_ifm_rready,
  input  word_u              m_ifm_rdata,
  input  logic               m_ifm_rlast,
  // wgt read channel
  output logic               m_wgt_arvalid,
  input  logic               m_wgt_arready,
  output addr_t              m_wgt_araddr,
  output logic [7:0]         m_wgt_arlen,
  input  logic               m_wgt_rvalid,
  output logic               m_wgt_rready,
  input  word_u              m_wgt_rdata,
  input  logic               m_wgt_rlast,
  // ofm write channel
  output logic               m_ofm_awvalid,
  input  logic               m_ofm_awready,
  output addr_t              m_ofm_awaddr,
  output logic [7:0]         m_ofm_awlen,
  output logic               m_ofm_wvalid,
  input  logic               m_ofm_wready,
  output word_u              m_ofm_wdata,
  output logic [n_bytes-1:0] m_ofm_wstrb,
  output logic               m_ofm_wlast,
  input  logic               m_ofm_bvalid,
  output logic               m_ofm_bready
);

  logic  op_start;
  logic  end_conv;
  logic  ifm_start;
  logic  wgt_start;
  logic  ofm_start;
  logic  ofm_done;
  word_u ofm_data;

  logic  ifm_axis_tvalid;
  logic  ifm_axis_tready;
  word_u ifm_axis_tdata;
  logic  ifm_axis_tlast;
  logic  wgt_axis_tvalid;
  logic  wgt_axis_tready;
  word_u wgt_axis_tdata;

  acc_eng_ctrl u_eng_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .ap_start (ap_start),
    .end_conv (end_conv),
    .ap_idle  (ap_idle),
    .ap_done  (ap_done),
    .ap_ready (ap_ready),
    .op_start (op_start)
  );

  mem_read_master #(.word_num(word_num)) u_ifm_read_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (ifm_start),
    .addr    (ifm_addr_base),
    .arvalid (m_ifm_arvalid),
    .arready (m_ifm_arready),
    .araddr  (m_ifm_araddr),
    .arlen   (m_ifm_arlen),
    .rvalid  (m_ifm_rvalid),
    .rready  (m_ifm_rready),
    .rdata   (m_ifm_rdata),
    .rlast   (m_ifm_rlast),
    .tvalid  (ifm_axis_tvalid),
    .tready  (ifm_axis_tready),
    .tdata   (ifm_axis_tdata),
    .tlast   (ifm_axis_tlast)
  );

  // weight tlast lines up with ifm tlast, the engine follows the ifm one
  mem_read_master #(.word_num(word_num)) u_wgt_read_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (wgt_start),
    .addr    (wgt_addr_base),
    .arvalid (m_wgt_arvalid),
    .arready (m_wgt_arready),
    .araddr  (m_wgt_araddr),
    .arlen   (m_wgt_arlen),
    .rvalid  (m_wgt_rvalid),
    .rready  (m_wgt_rready),
    .rdata   (m_wgt_rdata),
    .rlast   (m_wgt_rlast),
    .tvalid  (wgt_axis_tvalid),
    .tready  (wgt_axis_tready),
    .tdata   (wgt_axis_tdata),
    .tlast   ()
  );

  conv_engine #(.word_num(word_num)) u_conv_eng (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_start   (op_start),
    .ifm_start  (ifm_start),
    .wgt_start  (wgt_start),
    .ifm_tvalid (ifm_axis_tvalid),
    .ifm_tready (ifm_axis_tready),
    .ifm_tdata  (ifm_axis_tdata),
    .ifm_tlast  (ifm_axis_tlast),
    .wgt_tvalid (wgt_axis_tvalid),
    .wgt_tready (wgt_axis_tready),
    .wgt_tdata  (wgt_axis_tdata),
    .ofm_start  (ofm_start),
    .ofm_data   (ofm_data),
    .ofm_done   (ofm_done),
    .end_conv   (end_conv)
  );

  mem_write_master u_ofm_write_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (ofm_start),
    .addr    (ofm_addr_base),
    .data    (ofm_data),
    .awvalid (m_ofm_awvalid),
    .awready (m_ofm_awready),
    .awaddr  (m_ofm_awaddr),
    .awlen   (m_ofm_awlen),
    .wvalid  (m_ofm_wvalid),
    .wready  (m_ofm_wready),
    .wdata   (m_ofm_wdata),
    .wstrb   (m_ofm_wstrb),
    .wlast   (m_ofm_wlast),
    .bvalid  (m_ofm_bvalid),
    .bready  (m_ofm_bready),
    .done    (ofm_done)
  );

endmodule

// ==== verif/krnl_acc_asserts.sv ====
// sampled on the rising clock; every check is off while rst_n is low
`timescale 1ns/1ps

module krnl_acc_asserts (
  input logic clk,
  input logic rst_n,
  input logic ap_idle,
  input logic ap_done,
  input logic op_start,
  input logic m_ifm_arvalid,
  input logic m_ifm_arready,
  input logic m_wgt_arvalid,
  input logic m_wgt_arready,
  input logic m_ofm_awvalid,
  input logic m_ofm_awready
);

  // read back by the testbench at the end of the run
  int fail_cnt = 0;

  ifm_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_ifm_arvalid && !m_ifm_arready |=> m_ifm_arvalid)
    else begin
      fail_cnt++;
      $error("ifm arvalid dropped before arready");
    end

  wgt_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_wgt_arvalid && !m_wgt_arready |=> m_wgt_arvalid)
    else begin
      fail_cnt++;
      $error("wgt arvalid dropped before arready");
    end

  ofm_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_ofm_awvalid && !m_ofm_awready |=> m_ofm_awvalid)
    else begin
      fail_cnt++;
      $error("ofm awvalid dropped before awready");
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    ap_done |=> !ap_done)
    else begin
      fail_cnt++;
      $error("ap_done wider than one cycle");
    end

  // idle stays low after op_start and on the cycle before ap_done
  busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    op_start |=> !ap_idle)
    else begin
      fail_cnt++;
      $error("ap_idle high on the cycle after op_start");
    end

  done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    ap_done |-> $past(!ap_idle))
    else begin
      fail_cnt++;
      $error("ap_done without a busy cycle before it");
    end

endmodule

bind krnl_acc krnl_acc_asserts u_asserts (.*);

// ==== verif/krnl_acc_tb.sv ====
// memory model covers 1 KiB only; word_num fixed at 4 and every base lies inside that range
`timescale 1ns/1ps

module krnl_acc_tb import acc_pkg::*; ();

  localparam int word_num = 4;
  localparam int n_vec = 4;
  localparam int mem_size = 1024;
  localparam int timeout_cycles = 200;

  logic  clk;
  logic  rst_n;
  logic  ap_start;
  logic  ap_idle;
  logic  ap_done;
  logic  ap_ready;
  addr_t ifm_base;
  addr_t wgt_base;
  addr_t ofm_base;

  // index 0 is the ifm channel and 1 the wgt channel
  logic       rd_arvalid [2];
  logic       rd_arready [2];
  addr_t      rd_araddr [2];
  logic [7:0] rd_arlen [2];
  logic       rd_rvalid [2];
  logic       rd_rready [2];
  word_u      rd_rdata [2];
  logic       rd_rlast [2];

  logic               awvalid;
  logic               awready;
  addr_t              awaddr;
  logic [7:0]         awlen;
  logic               wvalid;
  logic               wready;
  word_u              wdata;
  logic [n_bytes-1:0] wstrb;
  logic               wlast;
  logic               bvalid;
  logic               bready;

  logic [7:0]        mem [mem_size];
  // words as they sit in memory with byte k at bits 8k+7:8k
  logic [data_w-1:0] tbl_ifm [n_vec][word_num];
  logic [data_w-1:0] tbl_wgt [n_vec][word_num];
  // ifm, wgt and ofm base per vector
  addr_t             tbl_base [n_vec][3];
  int                done_cnt = 0;
  int                ready_cnt = 0;

  krnl_acc #(.word_num(word_num)) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ap_start      (ap_start),
    .ap_idle       (ap_idle),
    .ap_done       (ap_done),
    .ap_ready      (ap_ready),
    .ifm_addr_base (ifm_base),
    .wgt_addr_base (wgt_base),
    .ofm_addr_base (ofm_base),
    .m_ifm_arvalid (rd_arvalid[0]),
    .m_ifm_arready (rd_arready[0]),
    .m_ifm_araddr  (rd_araddr[0]),
    .m_ifm_arlen   (rd_arlen[0]),
    .m_ifm_rvalid  (rd_rvalid[0]),
    .m_ifm_rready  (rd_rready[0]),
    .m_ifm_rdata   (rd_rdata[0]),
    .m_ifm_rlast   (rd_rlast[0]),
    .m_wgt_arvalid (rd_arvalid[1]),
    .m_wgt_arready (rd_arready[1]),
    .m_wgt_araddr  (rd_araddr[1]),
    .m_wgt_arlen   (rd_arlen[1]),
    .m_wgt_rvalid  (rd_rvalid[1]),
    .m_wgt_rready  (rd_rready[1]),
    .m_wgt_rdata   (rd_rdata[1]),
    .m_wgt_rlast   (rd_rlast[1]),
    .m_ofm_awvalid (awvalid),
    .m_ofm_awready (awready),
    .m_ofm_awaddr  (awaddr),
    .m_ofm_awlen   (awlen),
    .m_ofm_wvalid  (wvalid),
    .m_ofm_wready  (wready),
    .m_ofm_wdata   (wdata),
    .m_ofm_wstrb   (wstrb),
    .m_ofm_wlast   (wlast),
    .m_ofm_bvalid  (bvalid),
    .m_ofm_bready  (bready)
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (ap_done) done_cnt++;
    if (ap_ready) ready_cnt++;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string what, input word_u got, input word_u exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // little-endian word view of the byte memory
  function automatic word_u mem_word(input addr_t a);
    word_u w;
    for (int k = 0; k < n_bytes; k++) begin
      w.bytes[k] = mem[int'(a) + k];
    end
    return w;
  endfunction

  // reference model reverses each word, sums byte products per lane and reverses each lane
  function automatic word_u expected_result(input int v);
    word_u             in_i;
    word_u             in_w;
    word_u             res;
    logic [lane_w-1:0] sum [n_lanes];
    for (int l = 0; l < n_lanes; l++) begin
      sum[l] = '0;
    end
    for (int w = 0; w < word_num; w++) begin
      for (int i = 0; i < n_bytes; i++) begin
        in_i.bytes[i] = tbl_ifm[v][w][8*(n_bytes-1-i) +: 8];
        in_w.bytes[i] = tbl_wgt[v][w][8*(n_bytes-1-i) +: 8];
      end
      for (int i = 0; i < n_bytes; i++) begin
        sum[i/4] = sum[i/4] + lane_w'(in_i.bytes[i]) * lane_w'(in_w.bytes[i]);
      end
    end
    for (int l = 0; l < n_lanes; l++) begin
      for (int b = 0; b < 4; b++) begin
        res.bytes[4*l + b] = sum[l][8*(3-b) +: 8];
      end
    end
    return res;
  endfunction

  task automatic serve_read(input int ch, input addr_t base);
    int   waited;
    logic fired;
    waited = 0;
    while (!rd_arvalid[ch]) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure($sformatf("timeout: read channel %0d never raised arvalid", ch));
      end
    end
    check_addr("araddr", rd_araddr[ch], base);
    check_bit("arlen is 3", rd_arlen[ch] == 8'd3, 1'b1);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    rd_arready[ch] = 1'b1;
    @(negedge clk);
    rd_arready[ch] = 1'b0;
    for (int k = 0; k < word_num; k++) begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      rd_rvalid[ch] = 1'b1;
      rd_rdata[ch] = mem_word(base + addr_t'(8 * k));
      rd_rlast[ch] = (k == word_num - 1);
      waited = 0;
      fired = 1'b0;
      while (!fired) begin
        // rready settles once both channels have driven this cycle
        #1;
        fired = rd_rready[ch];
        @(negedge clk);
        waited++;
        if (waited > timeout_cycles) begin
          report_failure($sformatf("timeout: read channel %0d never took beat %0d", ch, k));
        end
      end
      rd_rvalid[ch] = 1'b0;
      rd_rlast[ch] = 1'b0;
    end
  endtask

  task automatic serve_write(input addr_t base);
    int waited;
    int da;
    int dw;
    waited = 0;
    while (!(awvalid && wvalid)) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure("timeout: write master never raised awvalid and wvalid");
      end
    end
    da = $urandom_range(3, 0);
    dw = $urandom_range(3, 0);
    for (int c = 0; c < 4; c++) begin
      awready = (c == da);
      wready = (c == dw);
      if (c == da) begin
        check_bit("awvalid held", awvalid, 1'b1);
        check_addr("awaddr", awaddr, base);
        check_bit("awlen is zero", awlen == 8'd0, 1'b1);
      end
      if (c == dw) begin
        check_bit("wvalid held", wvalid, 1'b1);
        check_bit("wlast", wlast, 1'b1);
        check_bit("wstrb all ones", &wstrb, 1'b1);
        for (int k = 0; k < n_bytes; k++) begin
          mem[int'(base) + k] = wdata.bytes[k];
        end
      end
      @(negedge clk);
    end
    awready = 1'b0;
    wready = 1'b0;
    waited = 0;
    while (!bready) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure("timeout: write master never raised bready");
      end
    end
    repeat ($urandom_range(3, 0)) @(negedge clk);
    bvalid = 1'b1;
    @(negedge clk);
    bvalid = 1'b0;
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (!ap_done) begin
      @(negedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        report_failure("timeout: ap_done never came");
      end
    end
  endtask

  task automatic run_vector(input int v);
    for (int w = 0; w < word_num; w++) begin
      for (int k = 0; k < n_bytes; k++) begin
        mem[int'(tbl_base[v][0]) + 8*w + k] = tbl_ifm[v][w][8*k +: 8];
        mem[int'(tbl_base[v][1]) + 8*w + k] = tbl_wgt[v][w][8*k +: 8];
      end
    end
    ifm_base = tbl_base[v][0];
    wgt_base = tbl_base[v][1];
    ofm_base = tbl_base[v][2];
    check_bit("ap_idle before start", ap_idle, 1'b1);
    ap_start = 1'b1;
    @(negedge clk);
    ap_start = 1'b0;
    fork
      serve_read(0, tbl_base[v][0]);
      serve_read(1, tbl_base[v][1]);
      serve_write(tbl_base[v][2]);
    join
    wait_for_done();
    check_bit("ap_ready with ap_done", ap_ready, 1'b1);
    check_bit("ap_idle with ap_done", ap_idle, 1'b1);
    repeat (2) @(negedge clk);
    check_word($sformatf("result of vector %0d", v), mem_word(tbl_base[v][2]),
               expected_result(v));
    check_bit("one ap_done per operation", done_cnt == v + 1, 1'b1);
    check_bit("one ap_ready per operation", ready_cnt == v + 1, 1'b1);
    check_bit("ap_idle after the operation", ap_idle, 1'b1);
  endtask

  initial begin
    void'($urandom(93075));
    clk = 1'b0;
    rst_n = 1'b0;
    ap_start = 1'b0;
    ifm_base = '0;
    wgt_base = '0;
    ofm_base = '0;
    for (int c = 0; c < 2; c++) begin
      rd_arready[c] = 1'b0;
      rd_rvalid[c] = 1'b0;
      rd_rdata[c] = '0;
      rd_rlast[c] = 1'b0;
    end
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    for (int i = 0; i < mem_size; i++) begin
      mem[i] = 8'(i ^ (i >> 8));
    end

    // distinct bytes against a single weight byte shows both swaps
    tbl_base[0] = '{64'h000, 64'h100, 64'h200};
    tbl_ifm[0] = '{64'h0807060504030201, 64'h100f0e0d0c0b0a09,
                   64'h1817161514131211, 64'h201f1e1d1c1b1a19};
    tbl_wgt[0] = '{default: 64'h0000000000000001};
    tbl_base[1] = '{64'h040, 64'h140, 64'h208};
    tbl_ifm[1] = '{64'h8877665544332211, 64'h1122334455667788,
                   64'hf0e0d0c0b0a09080, 64'h0f0e0d0c0b0a0908};
    tbl_wgt[1] = '{default: 64'h0001000000000000};
    // all ones gives the largest lane sums
    tbl_base[2] = '{64'h080, 64'h180, 64'h210};
    tbl_ifm[2] = '{default: 64'hffffffffffffffff};
    tbl_wgt[2] = '{default: 64'hffffffffffffffff};
    tbl_base[3] = '{64'h0c0, 64'h1c0, 64'h218};
    for (int w = 0; w < word_num; w++) begin
      tbl_ifm[3][w] = {$urandom, $urandom};
      tbl_wgt[3][w] = {$urandom, $urandom};
    end

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_bit("ap_idle after reset", ap_idle, 1'b1);
    check_bit("ap_done after reset", ap_done, 1'b0);
    check_bit("ap_ready after reset", ap_ready, 1'b0);
    check_bit("ifm arvalid after reset", rd_arvalid[0], 1'b0);
    check_bit("wgt arvalid after reset", rd_arvalid[1], 1'b0);
    check_bit("ifm rready after reset", rd_rready[0], 1'b0);
    check_bit("wgt rready after reset", rd_rready[1], 1'b0);
    check_bit("awvalid after reset", awvalid, 1'b0);
    check_bit("wvalid after reset", wvalid, 1'b0);
    check_bit("bready after reset", bready, 1'b0);

    for (int v = 0; v < n_vec; v++) begin
      run_vector(v);
    end

    if (dut0.u_asserts.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_failure("handshake assertions failed during the run");
    end
  end

endmodule

// ==== compile.f ====
design/acc_pkg.sv
design/acc_eng_ctrl.sv
design/mem_read_master.sv
design/mem_write_master.sv
design/conv_engine.sv
design/krnl_acc.sv
verif/krnl_acc_asserts.sv
verif/krnl_acc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of krnl_acc_tb; the verdict comes from the log
verilator --binary --timing --assert -Wno-fatal --top-module krnl_acc_tb -f compile.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vkrnl_acc_tb > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "Everything OK" sim.log && ! grep -q "Something failed" sim.log
